//--- logic/match3_cfg.svh
`ifndef MATCH3_CFG_SVH
`define MATCH3_CFG_SVH

////////////////////////////////////////////////////////////
// board geometry
////////////////////////////////////////////////////////////

`define BOARD_N       8
`define CELL_SIZE     32
`define CELL_SHIFT    5
`define BOARD_X0      272
`define BOARD_Y0      112

// symbol kinds, anything at or above NUM_KINDS is not a symbol
`define NUM_KINDS     5
`define CELL_EMPTY    7

`define SYMBOL_INSET  2
`define CURSOR_W      2

////////////////////////////////////////////////////////////
// palette, 4:4:4
////////////////////////////////////////////////////////////

`define RGB_WHITE     12'hfff
`define RGB_BLACK     12'h000
`define RGB_CURSOR    12'hf0f
`define RGB_KIND0     12'hf00
`define RGB_KIND1     12'h0c0
`define RGB_KIND2     12'h00f
`define RGB_KIND3     12'hfa0
`define RGB_KIND4     12'h0cc

`define LFSR_SEED     8'h5a

`endif

//--- logic/match3_pkg.sv
`include "match3_cfg.svh"

package match3_pkg;

    ////////////////////////////////////////////////////////////
    // shared vector types
    ////////////////////////////////////////////////////////////

    // pixel coordinate from the video timing
    typedef logic [9:0] pix_t;

    // 4 bits per colour channel
    typedef logic [11:0] rgb_t;

    // cell contents, 0..NUM_KINDS-1 or CELL_EMPTY
    typedef logic [2:0] kind_t;

    // row or column index on the board
    typedef logic [2:0] pos_t;

    // all cells packed flat, cell (r,c) in slot r*BOARD_N+c
    typedef logic [`BOARD_N*`BOARD_N*$bits(kind_t)-1:0] board_t;

    ////////////////////////////////////////////////////////////
    // fill sequencer states
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        FILL_IDLE = 2'd0,
        FILL_RUN  = 2'd1,
        FILL_DONE = 2'd2
    } fill_state_t;

endpackage

//--- logic/key_cursor.sv
`timescale 1ns/1ns
`include "match3_cfg.svh"

module key_cursor
    import match3_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic left,
    input  logic right,
    input  logic up,
    input  logic down,
    output pos_t cursor_row,
    output pos_t cursor_col
);

    localparam pos_t POS_MAX = pos_t'(`BOARD_N - 1);

    // key levels from the previous clock
    logic left_q;
    logic right_q;
    logic up_q;
    logic down_q;

    logic left_rise;
    logic right_rise;
    logic up_rise;
    logic down_rise;

    assign left_rise  = left  && !left_q;
    assign right_rise = right && !right_q;
    assign up_rise    = up    && !up_q;
    assign down_rise  = down  && !down_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            left_q     <= 1'b0;
            right_q    <= 1'b0;
            up_q       <= 1'b0;
            down_q     <= 1'b0;
            cursor_row <= POS_MAX;
            cursor_col <= '0;
        end else begin
            left_q  <= left;
            right_q <= right;
            up_q    <= up;
            down_q  <= down;
            // left wins over right, up over down; both saturate
            if (left_rise) begin
                if (cursor_col != '0)
                    cursor_col <= cursor_col - 1'b1;
            end else if (right_rise && cursor_col != POS_MAX) begin
                cursor_col <= cursor_col + 1'b1;
            end
            if (up_rise) begin
                if (cursor_row != '0)
                    cursor_row <= cursor_row - 1'b1;
            end else if (down_rise && cursor_row != POS_MAX) begin
                cursor_row <= cursor_row + 1'b1;
            end
        end
    end

    // a key pressed against the edge leaves the cursor where it is
    a_col_limit: assert property (@(posedge clk) disable iff (reset)
        ((left_rise && cursor_col == '0) ||
         (right_rise && !left_rise && cursor_col == POS_MAX)) |=> $stable(cursor_col));

    a_row_limit: assert property (@(posedge clk) disable iff (reset)
        ((up_rise && cursor_row == '0) ||
         (down_rise && !up_rise && cursor_row == POS_MAX)) |=> $stable(cursor_row));

endmodule

//--- logic/rand_lfsr.sv
`timescale 1ns/1ns
`include "match3_cfg.svh"

module rand_lfsr
    import match3_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output kind_t rand_kind
);

    // x^8 + x^6 + x^5 + x^4 + 1, right-shifting galois form
    localparam logic [7:0] TAPS = 8'hb8;

    logic [7:0] state_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= `LFSR_SEED;
        end else begin
            state_q <= {1'b0, state_q[7:1]} ^ (state_q[0] ? TAPS : 8'h00);
        end
    end

    // low bits only, board_fill throws away the large draws
    assign rand_kind = state_q[$bits(kind_t)-1:0];

    // the all-zero state would lock up the sequence
    a_state_nonzero: assert property (@(posedge clk) disable iff (reset)
        state_q != 8'h00);

endmodule

//--- logic/board_fill.sv
`timescale 1ns/1ns
`include "match3_cfg.svh"

module board_fill
    import match3_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  game_reset,
    input  kind_t rand_kind,
    output logic  fill_we,
    output logic  filling,
    output pos_t  fill_row,
    output pos_t  fill_col,
    output kind_t fill_kind
);

    localparam int POS_W = $bits(pos_t);
    localparam logic [2*POS_W-1:0] LAST_CELL = '1;

    fill_state_t state_q;
    logic [2*POS_W-1:0] cell_q;
    logic accept;

    // draws of NUM_KINDS and above are skipped, try again next clock
    assign accept = (state_q == FILL_RUN) && (rand_kind < kind_t'(`NUM_KINDS));

    ////////////////////////////////////////////////////////////
    // fill sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= FILL_IDLE;
            cell_q  <= '0;
        end else begin
            case (state_q)
                FILL_IDLE: begin
                    if (game_reset) begin
                        state_q <= FILL_RUN;
                        cell_q  <= '0;
                    end
                end
                FILL_RUN: begin
                    if (accept) begin
                        if (cell_q == LAST_CELL)
                            state_q <= FILL_DONE;
                        cell_q <= cell_q + 1'b1;
                    end
                end
                FILL_DONE: begin
                    // one sweep per game_reset press
                    if (!game_reset)
                        state_q <= FILL_IDLE;
                end
                default: state_q <= FILL_IDLE;
            endcase
        end
    end

    // row-major walk
    assign fill_row  = cell_q[2*POS_W-1:POS_W];
    assign fill_col  = cell_q[POS_W-1:0];
    assign fill_we   = accept;
    assign fill_kind = rand_kind;
    assign filling   = (state_q != FILL_IDLE);

    a_fill_kind: assert property (@(posedge clk) disable iff (reset)
        fill_we |-> (fill_kind < kind_t'(`NUM_KINDS)));

endmodule

//--- logic/board_store.sv
`timescale 1ns/1ns
`include "match3_cfg.svh"

module board_store
    import match3_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   fill_we,
    input  logic   filling,
    input  pos_t   fill_row,
    input  pos_t   fill_col,
    input  kind_t  fill_kind,
    output board_t board
);

    localparam int N = `BOARD_N;
    localparam int KW = $bits(kind_t);
    localparam kind_t EMPTY = kind_t'(`CELL_EMPTY);

    kind_t cell_q [N*N];
    kind_t cell_next [N*N];
    logic [N*N-1:0] hit;
    logic bad_kind;

    ////////////////////////////////////////////////////////////
    // triple detection
    ////////////////////////////////////////////////////////////

    // every run is found on the current board, all cleared together
    always_comb begin : match_scan
        hit = '0;
        // horizontal
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N - 2; c++) begin
                if (cell_q[r*N+c] == cell_q[r*N+c+1] &&
                    cell_q[r*N+c] == cell_q[r*N+c+2]) begin
                    hit[r*N+c]   = 1'b1;
                    hit[r*N+c+1] = 1'b1;
                    hit[r*N+c+2] = 1'b1;
                end
            end
        end
        // vertical
        for (int r = 0; r < N - 2; r++) begin
            for (int c = 0; c < N; c++) begin
                if (cell_q[r*N+c] == cell_q[(r+1)*N+c] &&
                    cell_q[r*N+c] == cell_q[(r+2)*N+c]) begin
                    hit[r*N+c]     = 1'b1;
                    hit[(r+1)*N+c] = 1'b1;
                    hit[(r+2)*N+c] = 1'b1;
                end
            end
        end
    end

    always_comb begin : next_cells
        bad_kind = 1'b0;
        for (int i = 0; i < N*N; i++) begin
            cell_next[i] = hit[i] ? EMPTY : cell_q[i];
            board[i*KW +: KW] = cell_q[i];
            if (cell_q[i] >= kind_t'(`NUM_KINDS) && cell_q[i] != EMPTY)
                bad_kind = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // cell registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < N*N; i++)
                cell_q[i] <= EMPTY;
        end else if (filling) begin
            // no clearing while the board is being refilled
            if (fill_we)
                cell_q[{fill_row, fill_col}] <= fill_kind;
        end else begin
            for (int i = 0; i < N*N; i++)
                cell_q[i] <= cell_next[i];
        end
    end

    // only accepted draws or the empty code ever reach a cell
    a_kind_range: assert property (@(posedge clk) disable iff (reset) !bad_kind);

endmodule

//--- logic/pixel_render.sv
`timescale 1ns/1ns
`include "match3_cfg.svh"

module pixel_render
    import match3_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   video_on,
    input  pix_t   pix_x,
    input  pix_t   pix_y,
    input  board_t board,
    input  pos_t   cursor_row,
    input  pos_t   cursor_col,
    output rgb_t   graph_rgb
);

    localparam int SHIFT = `CELL_SHIFT;
    localparam int KW = $bits(kind_t);
    localparam int POS_W = $bits(pos_t);
    localparam pix_t X0 = pix_t'(`BOARD_X0);
    localparam pix_t Y0 = pix_t'(`BOARD_Y0);
    localparam pix_t X_END = pix_t'(`BOARD_X0 + `BOARD_N * `CELL_SIZE);
    localparam pix_t Y_END = pix_t'(`BOARD_Y0 + `BOARD_N * `CELL_SIZE);

    // symbol area and cursor ring inside a cell
    localparam logic [SHIFT-1:0] SYM_LO = SHIFT'(`SYMBOL_INSET);
    localparam logic [SHIFT-1:0] SYM_HI = SHIFT'(`CELL_SIZE - `SYMBOL_INSET - 1);
    localparam logic [SHIFT-1:0] CUR_LO = SHIFT'(`CURSOR_W);
    localparam logic [SHIFT-1:0] CUR_HI = SHIFT'(`CELL_SIZE - `CURSOR_W - 1);

    pix_t off_x;
    pix_t off_y;
    logic in_board;
    pos_t cell_row;
    pos_t cell_col;
    logic [SHIFT-1:0] sub_x;
    logic [SHIFT-1:0] sub_y;
    logic [2*POS_W-1:0] cell_idx;
    kind_t cell_kind;
    logic sym_on;
    logic cursor_on;
    rgb_t kind_rgb;
    rgb_t rgb_next;

    ////////////////////////////////////////////////////////////
    // cell lookup
    ////////////////////////////////////////////////////////////

    assign off_x = pix_x - X0;
    assign off_y = pix_y - Y0;
    assign in_board = (pix_x >= X0) && (pix_x < X_END) && (pix_y >= Y0) && (pix_y < Y_END);

    assign cell_col = off_x[SHIFT +: POS_W];
    assign cell_row = off_y[SHIFT +: POS_W];
    assign sub_x    = off_x[SHIFT-1:0];
    assign sub_y    = off_y[SHIFT-1:0];

    assign cell_idx  = {cell_row, cell_col};
    assign cell_kind = board[int'(cell_idx)*KW +: KW];

    assign sym_on = in_board && (cell_kind != kind_t'(`CELL_EMPTY)) &&
                    (sub_x >= SYM_LO) && (sub_x <= SYM_HI) &&
                    (sub_y >= SYM_LO) && (sub_y <= SYM_HI);

    // border ring of the selected cell
    assign cursor_on = in_board && (cell_row == cursor_row) && (cell_col == cursor_col) &&
                       ((sub_x < CUR_LO) || (sub_x > CUR_HI) ||
                        (sub_y < CUR_LO) || (sub_y > CUR_HI));

    ////////////////////////////////////////////////////////////
    // palette and colour mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (cell_kind)
            3'd0:    kind_rgb = `RGB_KIND0;
            3'd1:    kind_rgb = `RGB_KIND1;
            3'd2:    kind_rgb = `RGB_KIND2;
            3'd3:    kind_rgb = `RGB_KIND3;
            3'd4:    kind_rgb = `RGB_KIND4;
            default: kind_rgb = `RGB_WHITE;
        endcase
    end

    always_comb begin
        if (!video_on)
            rgb_next = `RGB_BLACK;
        else if (cursor_on)
            rgb_next = `RGB_CURSOR;
        else if (sym_on)
            rgb_next = kind_rgb;
        else
            rgb_next = `RGB_WHITE;
    end

    // one clock behind the pixel coordinates
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            graph_rgb <= `RGB_BLACK;
        else
            graph_rgb <= rgb_next;
    end

endmodule

//--- logic/match3_top.sv
`timescale 1ns/1ns

module match3_top
    import match3_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic video_on,
    input  pix_t pix_x,
    input  pix_t pix_y,
    input  logic left,
    input  logic right,
    input  logic up,
    input  logic down,
    input  logic game_reset,
    output rgb_t graph_rgb
);

    // cursor position
    pos_t cursor_row;
    pos_t cursor_col;

    // fill path
    kind_t rand_kind;
    logic fill_we;
    logic filling;
    pos_t fill_row;
    pos_t fill_col;
    kind_t fill_kind;

    board_t board;

    key_cursor key_cursor_i (
        .clk        (clk),
        .reset      (reset),
        .left       (left),
        .right      (right),
        .up         (up),
        .down       (down),
        .cursor_row (cursor_row),
        .cursor_col (cursor_col)
    );

    rand_lfsr rand_lfsr_i (
        .clk       (clk),
        .reset     (reset),
        .rand_kind (rand_kind)
    );

    board_fill board_fill_i (
        .clk        (clk),
        .reset      (reset),
        .game_reset (game_reset),
        .rand_kind  (rand_kind),
        .fill_we    (fill_we),
        .filling    (filling),
        .fill_row   (fill_row),
        .fill_col   (fill_col),
        .fill_kind  (fill_kind)
    );

    board_store board_store_i (
        .clk       (clk),
        .reset     (reset),
        .fill_we   (fill_we),
        .filling   (filling),
        .fill_row  (fill_row),
        .fill_col  (fill_col),
        .fill_kind (fill_kind),
        .board     (board)
    );

    pixel_render pixel_render_i (
        .clk        (clk),
        .reset      (reset),
        .video_on   (video_on),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .board      (board),
        .cursor_row (cursor_row),
        .cursor_col (cursor_col),
        .graph_rgb  (graph_rgb)
    );

endmodule

//--- bench/match3_tb.sv
`timescale 1ns/1ns
`include "match3_cfg.svh"

module match3_tb
    import match3_pkg::*;
();

    localparam int N = `BOARD_N;
    localparam int HALF = `CELL_SIZE / 2;

    typedef int cell_arr_t [`BOARD_N*`BOARD_N];

    logic clk;
    logic reset;
    logic video_on;
    pix_t pix_x;
    pix_t pix_y;
    logic left;
    logic right;
    logic up;
    logic down;
    logic game_reset;
    rgb_t graph_rgb;

    // board images in row-major order with CELL_EMPTY for a white cell
    cell_arr_t read_cells;
    cell_arr_t prev_cells;
    cell_arr_t filled_cells;
    cell_arr_t expect_cells;

    logic [31:0] lcg_state;
    int cur_row;
    int cur_col;

    match3_top match3_top_i (
        .clk        (clk),
        .reset      (reset),
        .video_on   (video_on),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .left       (left),
        .right      (right),
        .up         (up),
        .down       (down),
        .game_reset (game_reset),
        .graph_rgb  (graph_rgb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        stop_run($sformatf("[ERROR] %0t ns: %s", $time, msg));
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    function automatic int colour_to_kind(input rgb_t rgb);
        case (rgb)
            `RGB_WHITE: return `CELL_EMPTY;
            `RGB_KIND0: return 0;
            `RGB_KIND1: return 1;
            `RGB_KIND2: return 2;
            `RGB_KIND3: return 3;
            `RGB_KIND4: return 4;
            default:    return -1;
        endcase
    endfunction

    // colour is registered so it shows one clock after the pixel
    task automatic probe_pixel(input int x, input int y, output rgb_t rgb);
        pix_x = pix_t'(x);
        pix_y = pix_t'(y);
        next_cycle();
        rgb = graph_rgb;
    endtask

    task automatic read_board();
        rgb_t rgb;
        for (int i = 0; i < N * N; i++) begin
            probe_pixel(`BOARD_X0 + (i % N) * `CELL_SIZE + HALF,
                        `BOARD_Y0 + (i / N) * `CELL_SIZE + HALF, rgb);
            read_cells[i] = colour_to_kind(rgb);
            assert (read_cells[i] >= 0) else
                report_error($sformatf("cell %0d shows colour %03h", i, rgb));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference clearing rule
    ////////////////////////////////////////////////////////////

    // every run of three in a line empties out as judged on the input board
    function automatic void clear_runs(input cell_arr_t cur, output cell_arr_t nxt);
        nxt = cur;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                if (c + 2 < N && cur[r*N+c] == cur[r*N+c+1] &&
                    cur[r*N+c] == cur[r*N+c+2]) begin
                    nxt[r*N+c]   = `CELL_EMPTY;
                    nxt[r*N+c+1] = `CELL_EMPTY;
                    nxt[r*N+c+2] = `CELL_EMPTY;
                end
                if (r + 2 < N && cur[r*N+c] == cur[(r+1)*N+c] &&
                    cur[r*N+c] == cur[(r+2)*N+c]) begin
                    nxt[r*N+c]     = `CELL_EMPTY;
                    nxt[(r+1)*N+c] = `CELL_EMPTY;
                    nxt[(r+2)*N+c] = `CELL_EMPTY;
                end
            end
        end
    endfunction

    task automatic compare_board(input string what);
        for (int i = 0; i < N * N; i++) begin
            assert (read_cells[i] == expect_cells[i]) else
                report_error($sformatf("%s: cell %0d reads %0d, expected %0d",
                                       what, i, read_cells[i], expect_cells[i]));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // cursor stimulus
    ////////////////////////////////////////////////////////////

    task automatic press_key(input int which);
        case (which)
            0: left = 1'b1;
            1: right = 1'b1;
            2: up = 1'b1;
            default: down = 1'b1;
        endcase
        next_cycle();
        next_cycle();
        left = 1'b0;
        right = 1'b0;
        up = 1'b0;
        down = 1'b0;
        next_cycle();
        next_cycle();
    endtask

    task automatic check_cursor(input int prev_row, input int prev_col);
        rgb_t rgb;
        probe_pixel(`BOARD_X0 + cur_col * `CELL_SIZE, `BOARD_Y0 + cur_row * `CELL_SIZE, rgb);
        assert (rgb == `RGB_CURSOR) else
            report_error($sformatf("no cursor at (%0d,%0d), colour %03h", cur_row, cur_col, rgb));
        if (prev_row != cur_row || prev_col != cur_col) begin
            probe_pixel(`BOARD_X0 + prev_col * `CELL_SIZE,
                        `BOARD_Y0 + prev_row * `CELL_SIZE, rgb);
            assert (rgb != `RGB_CURSOR) else
                report_error($sformatf("cursor left behind at (%0d,%0d)", prev_row, prev_col));
        end
    endtask

    // fill time varies with the random draws so read until two reads agree
    task automatic wait_fill_settled();
        int reads;
        logic same;
        reads = 0;
        same = 1'b0;
        read_board();
        while (!same) begin
            if (reads >= 200)
                stop_run("timeout: board still changing after 200 reads during fill");
            prev_cells = read_cells;
            read_board();
            reads++;
            same = 1'b1;
            for (int i = 0; i < N * N; i++) begin
                if (read_cells[i] != prev_cells[i])
                    same = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main_seq
        int which;
        int prev_row;
        int prev_col;
        rgb_t rgb;
        reset = 1'b1;
        video_on = 1'b0;
        pix_x = '0;
        pix_y = '0;
        left = 1'b0;
        right = 1'b0;
        up = 1'b0;
        down = 1'b0;
        game_reset = 1'b0;
        lcg_state = 32'ha9ee;
        cur_row = N - 1;
        cur_col = 0;
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;

        // blanking then an empty board
        next_cycle();
        assert (graph_rgb == `RGB_BLACK) else
            report_error($sformatf("blanked pixel shows %03h", graph_rgb));
        video_on = 1'b1;
        read_board();
        for (int i = 0; i < N * N; i++)
            expect_cells[i] = `CELL_EMPTY;
        compare_board("empty board");
        // right of the board on the cursor row where the cell offset wraps to column 0
        probe_pixel(`BOARD_X0 + N * `CELL_SIZE, `BOARD_Y0 + (N - 1) * `CELL_SIZE, rgb);
        assert (rgb == `RGB_WHITE) else
            report_error($sformatf("pixel outside the board shows %03h", rgb));

        for (int k = 0; k < 40; k++) begin
            lcg_state = lcg_next(lcg_state);
            which = int'(lcg_state[31:30]);
            prev_row = cur_row;
            prev_col = cur_col;
            press_key(which);
            case (which)
                0: if (cur_col > 0) cur_col--;
                1: if (cur_col < N - 1) cur_col++;
                2: if (cur_row > 0) cur_row--;
                default: if (cur_row < N - 1) cur_row++;
            endcase
            check_cursor(prev_row, prev_col);
        end

        // two fill and clear rounds
        for (int round = 0; round < 2; round++) begin
            game_reset = 1'b1;
            wait_fill_settled();
            for (int i = 0; i < N * N; i++) begin
                assert (read_cells[i] >= 0 && read_cells[i] < `NUM_KINDS) else
                    report_error($sformatf("filled cell %0d holds %0d", i, read_cells[i]));
            end
            filled_cells = read_cells;
            game_reset = 1'b0;
            repeat (4) next_cycle();
            clear_runs(filled_cells, expect_cells);
            read_board();
            compare_board("after clear");
            repeat (50) next_cycle();
            read_board();
            compare_board("50 cycles later");
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- match3_top.f
+incdir+logic
logic/match3_pkg.sv
logic/key_cursor.sv
logic/rand_lfsr.sv
logic/board_fill.sv
logic/board_store.sv
logic/pixel_render.sv
logic/match3_top.sv
bench/match3_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the match3 testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    -f match3_top.f --top-module match3_tb -o match3_sim

# the log decides the result
./obj_dir/match3_sim | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
